// ==== hw/matrix_defines.svh ====
// panel geometry, bit-plane depth and brightness timer constants
// plus the counter and address widths derived from them
`ifndef MATRIX_DEFINES_SVH
`define MATRIX_DEFINES_SVH

// columns per line, shifted out once per bit plane
`define MATRIX_WIDTH 64

// rows per half-panel, full image is twice this
`define MATRIX_HALFHEIGHT 16

// bits per colour channel, one bit plane each
`define BRIGHTNESS_LEVELS 4

// lit cycles of the least significant plane
`define BRIGHTNESS_BASE_TIMEOUT 8

// next line may start shifting once this few lit cycles remain
`define BRIGHTNESS_OVERLAP 4

// derived widths
`define COLUMN_ADDR_WIDTH ($clog2(`MATRIX_WIDTH))
`define ROW_ADDR_WIDTH ($clog2(`MATRIX_HALFHEIGHT))
// load counter has to hold MATRIX_WIDTH itself
`define LOAD_COUNTER_WIDTH (`COLUMN_ADDR_WIDTH + 1)
// lit time of the most significant plane
`define BRIGHTNESS_MAX_TIMEOUT (`BRIGHTNESS_BASE_TIMEOUT << (`BRIGHTNESS_LEVELS - 1))
`define BRIGHTNESS_COUNTER_WIDTH ($clog2(`BRIGHTNESS_MAX_TIMEOUT) + 1)

`endif

// ==== hw/matrix_pkg.sv ====
// address, plane mask and colour types
// packed HUB75 panel bus and pixel write request
`include "matrix_defines.svh"

package matrix_pkg;

    // column within a line, 63 down to 0 during a shift
    typedef logic [`COLUMN_ADDR_WIDTH-1:0] column_addr_t;
    // row within one half-panel
    typedef logic [`ROW_ADDR_WIDTH-1:0] row_addr_t;
    // row of the full image, top bit picks the lower half
    typedef logic [`ROW_ADDR_WIDTH:0] image_row_t;

    // one-hot bit plane select
    typedef logic [`BRIGHTNESS_LEVELS-1:0] brightness_mask_t;
    // intensity of one colour
    typedef logic [`BRIGHTNESS_LEVELS-1:0] channel_t;

    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } pixel_rgb_t;

    // one bit plane of one column, both halves
    typedef struct packed {
        logic r0;
        logic g0;
        logic b0;
        logic r1;
        logic g1;
        logic b1;
    } line_bits_t;

    // what leaves the chip towards the panel connector
    typedef struct packed {
        line_bits_t line_bits;
        row_addr_t row_address_active;
        logic clk_pixel;
        logic row_latch;
        logic output_enable;
    } hub75_bus_t;

    // single pixel write from the image source
    typedef struct packed {
        image_row_t row;
        column_addr_t column;
        pixel_rgb_t pixel;
    } pixel_write_t;

endpackage

// ==== hw/timeout.sv ====
// loadable down-counter, stops at zero
// running stays high while the count is non-zero
`timescale 1ns/1ps

module timeout #(
    parameter int COUNTER_WIDTH = 8
) (
    input logic reset,
    input logic clk_in,
    input logic start,
    input logic [COUNTER_WIDTH-1:0] value,
    output logic [COUNTER_WIDTH-1:0] counter,
    output logic running
);

    // start wins over the decrement, so a restart mid-count reloads
    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            counter <= value;
        end else if (counter != '0) begin
            // count down, hold at zero
            counter <= counter - 1'b1;
        end
    end

    // high for exactly value cycles after a start
    assign running = (counter != '0);

endmodule

// ==== hw/brightness_timeout.sv ====
// lit-time timer for binary-coded modulation
// output enable per bit plane, overlap flag for the next line
`timescale 1ns/1ps
`include "matrix_defines.svh"

module brightness_timeout
    import matrix_pkg::*;
(
    input logic reset,
    input logic clk_in,
    input logic row_latch,
    input brightness_mask_t brightness_mask_active,
    output logic output_enable,
    output logic exceeded_overlap_time
);

    typedef logic [`BRIGHTNESS_COUNTER_WIDTH-1:0] lit_count_t;

    // lit time for the plane just latched
    lit_count_t lit_time;
    // lit cycles still to go
    lit_count_t remaining;

    // one-hot mask to base timeout doubled per plane index
    // plane 0 -> base, plane 3 -> base * 8
    always_comb begin
        lit_time = '0;
        for (int plane = 0; plane < `BRIGHTNESS_LEVELS; plane++) begin
            if (brightness_mask_active[plane]) begin
                lit_time = lit_count_t'(`BRIGHTNESS_BASE_TIMEOUT) << plane;
            end
        end
    end

    // a latch always restarts the lit period
    // even if the previous one has not run out yet
    always_ff @(posedge clk_in) begin
        if (reset) begin
            remaining <= '0;
        end else if (row_latch) begin
            remaining <= lit_time;
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    // LEDs on while time is left
    // goes high the cycle after the latch, for lit_time cycles
    assign output_enable = (remaining != '0);

    // close enough to the end that the next shift can begin
    // also true when dark, count is zero then
    assign exceeded_overlap_time = (remaining <= lit_count_t'(`BRIGHTNESS_OVERLAP));

endmodule

// ==== hw/matrix_scan.sv ====
// scan engine: line start, gated load and pixel clocks, row latch
// row and bit-plane sequencing, brightness timer instance
`timescale 1ns/1ps
`include "matrix_defines.svh"

module matrix_scan
    import matrix_pkg::*;
(
    input logic reset,
    input logic clk_in,
    // column being loaded now
    output column_addr_t column_address,
    // row being shifted now
    output row_addr_t row_address,
    // row currently lit
    output row_addr_t row_address_active,
    output logic clk_pixel_load,
    output logic clk_pixel,
    output logic row_latch,
    output logic output_enable,
    // plane being shifted now
    output brightness_mask_t brightness_mask
);

    localparam int LOAD_WIDTH = `LOAD_COUNTER_WIDTH;
    typedef logic [LOAD_WIDTH-1:0] load_count_t;

    localparam brightness_mask_t MASK_MSB = brightness_mask_t'(1) << (`BRIGHTNESS_LEVELS - 1);
    localparam row_addr_t LAST_ROW = row_addr_t'(`MATRIX_HALFHEIGHT - 1);

    // line start
    logic state_advance;
    logic [1:0] advance_shift;
    logic line_start;
    logic line_busy;

    // load and pixel clock gating
    logic load_running;
    logic clk_pixel_load_en;
    logic clk_pixel_en;
    logic [1:0] latch_shift;
    logic latch_next;

    // brightness timer
    logic exceeded_overlap_time;
    brightness_mask_t brightness_mask_active;

    // next line may go once the panel is dark or nearly done
    // never while a line is still in flight
    assign state_advance = (!output_enable || exceeded_overlap_time) && !line_busy;

    // condition has to hold two cycles in a row
    assign line_start = (advance_shift == 2'b11) && !line_busy;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            advance_shift <= 2'b00;
            line_busy <= 1'b0;
        end else begin
            advance_shift <= {advance_shift[0], state_advance};
            // busy from start until the latch ends the line
            if (line_start) begin
                line_busy <= 1'b1;
            end else if (row_latch) begin
                line_busy <= 1'b0;
            end
        end
    end

    // MATRIX_WIDTH cycles of load enable per line
    timeout #(
        .COUNTER_WIDTH(LOAD_WIDTH)
    ) load_timer (
        .reset  (reset),
        .clk_in (clk_in),
        .start  (line_start),
        .value  (load_count_t'(`MATRIX_WIDTH)),
        .counter(),
        .running(load_running)
    );

    // column address, last column first, stops at 0
    timeout #(
        .COUNTER_WIDTH(`COLUMN_ADDR_WIDTH)
    ) column_timer (
        .reset  (reset),
        .clk_in (clk_in),
        .start  (line_start),
        .value  (column_addr_t'(`MATRIX_WIDTH - 1)),
        .counter(column_address),
        .running()
    );

    // latch rises on the falling edge after the last load drops out
    assign latch_next = latch_shift[0] && !clk_pixel_load_en;

    // falling-edge side, enables only change while clk_in is low
    // so the gated clocks come out clean
    always_ff @(negedge clk_in) begin
        if (reset) begin
            clk_pixel_load_en <= 1'b0;
            latch_shift <= 2'b00;
            brightness_mask <= MASK_MSB;
            brightness_mask_active <= '0;
            row_address <= '0;
            row_address_active <= '0;
        end else begin
            clk_pixel_load_en <= load_running;
            // stage 0 doubles as pixel clock enable, one cycle behind load
            latch_shift <= {latch_shift[0], clk_pixel_load_en};
            if (latch_next) begin
                // shifted line becomes the lit line
                brightness_mask_active <= brightness_mask;
                row_address_active <= row_address;
                if (brightness_mask[0]) begin
                    // LSB plane done, back to MSB on the next row
                    brightness_mask <= MASK_MSB;
                    if (row_address == LAST_ROW) begin
                        row_address <= '0;
                    end else begin
                        row_address <= row_address + 1'b1;
                    end
                end else begin
                    brightness_mask <= brightness_mask >> 1;
                end
            end
        end
    end

    assign clk_pixel_en = latch_shift[0];
    // one cycle wide, right after the last pixel clock
    assign row_latch = latch_shift[1] && !latch_shift[0];

    // gated clocks
    assign clk_pixel_load = clk_in && clk_pixel_load_en;
    assign clk_pixel = clk_in && clk_pixel_en;

    brightness_timeout brightness_timer (
        .reset                 (reset),
        .clk_in                (clk_in),
        .row_latch             (row_latch),
        .brightness_mask_active(brightness_mask_active),
        .output_enable         (output_enable),
        .exceeded_overlap_time (exceeded_overlap_time)
    );

endmodule

// ==== hw/frame_store.sv ====
// full-image pixel memory, one write port
// registered upper/lower bit-plane read on the pixel load clock
`timescale 1ns/1ps
`include "matrix_defines.svh"

module frame_store
    import matrix_pkg::*;
(
    input logic clk_in,
    input logic wr_en,
    input pixel_write_t wr,
    // gated load clock from the scan engine
    input logic clk_pixel_load,
    input column_addr_t column_address,
    input row_addr_t row_address,
    input brightness_mask_t brightness_mask,
    output line_bits_t line_bits
);

    // both half-panels, row-major
    localparam int DEPTH = 2 * `MATRIX_HALFHEIGHT * `MATRIX_WIDTH;
    localparam int ADDR_WIDTH = $clog2(DEPTH);
    typedef logic [ADDR_WIDTH-1:0] pixel_addr_t;

    pixel_rgb_t pixels [DEPTH];

    image_row_t upper_row;
    image_row_t lower_row;
    pixel_addr_t write_addr;
    pixel_addr_t upper_addr;
    pixel_addr_t lower_addr;
    pixel_rgb_t upper_pixel;
    pixel_rgb_t lower_pixel;

    // bit of one channel in the selected plane
    function automatic logic plane_bit(channel_t channel, brightness_mask_t mask);
        return |(channel & mask);
    endfunction

    // writer side, any time, no back-pressure
    assign write_addr = {wr.row, wr.column};

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            pixels[write_addr] <= wr.pixel;
        end
    end

    // lower half sits MATRIX_HALFHEIGHT rows further down
    assign upper_row = {1'b0, row_address};
    assign lower_row = {1'b1, row_address};
    assign upper_addr = {upper_row, column_address};
    assign lower_addr = {lower_row, column_address};

    assign upper_pixel = pixels[upper_addr];
    assign lower_pixel = pixels[lower_addr];

    // one column per load pulse, ready for the following pixel clock
    always_ff @(posedge clk_pixel_load) begin
        line_bits.r0 <= plane_bit(upper_pixel.red, brightness_mask);
        line_bits.g0 <= plane_bit(upper_pixel.green, brightness_mask);
        line_bits.b0 <= plane_bit(upper_pixel.blue, brightness_mask);
        line_bits.r1 <= plane_bit(lower_pixel.red, brightness_mask);
        line_bits.g1 <= plane_bit(lower_pixel.green, brightness_mask);
        line_bits.b1 <= plane_bit(lower_pixel.blue, brightness_mask);
    end

endmodule

// ==== hw/led_matrix.sv ====
// LED matrix top level
// frame store and scan engine, packed HUB75 output bus
`timescale 1ns/1ps

module led_matrix
    import matrix_pkg::*;
(
    input logic reset,
    input logic clk_in,
    input logic wr_en,
    input pixel_write_t wr,
    output hub75_bus_t hub75
);

    // scan engine to frame store
    column_addr_t column_address;
    row_addr_t row_address;
    brightness_mask_t brightness_mask;
    logic clk_pixel_load;

    // panel side
    line_bits_t line_bits;
    row_addr_t row_address_active;
    logic clk_pixel;
    logic row_latch;
    logic output_enable;

    frame_store store (
        .clk_in         (clk_in),
        .wr_en          (wr_en),
        .wr             (wr),
        .clk_pixel_load (clk_pixel_load),
        .column_address (column_address),
        .row_address    (row_address),
        .brightness_mask(brightness_mask),
        .line_bits      (line_bits)
    );

    matrix_scan scan (
        .reset             (reset),
        .clk_in            (clk_in),
        .column_address    (column_address),
        .row_address       (row_address),
        .row_address_active(row_address_active),
        .clk_pixel_load    (clk_pixel_load),
        .clk_pixel         (clk_pixel),
        .row_latch         (row_latch),
        .output_enable     (output_enable),
        .brightness_mask   (brightness_mask)
    );

    // pack for the connector
    assign hub75.line_bits = line_bits;
    assign hub75.row_address_active = row_address_active;
    assign hub75.clk_pixel = clk_pixel;
    assign hub75.row_latch = row_latch;
    assign hub75.output_enable = output_enable;

endmodule

// ==== sim/tb_led_matrix.sv ====
// testbench for the LED matrix scan controller
// random image writer, panel bus monitor, reference model and checks
`timescale 1ns/1ps
`include "matrix_defines.svh"

module tb_led_matrix
    import matrix_pkg::*;
();

    localparam int WIDTH = `MATRIX_WIDTH;
    localparam int HALF = `MATRIX_HALFHEIGHT;
    localparam int LEVELS = `BRIGHTNESS_LEVELS;
    localparam int FRAME_LINES = HALF * LEVELS;
    // first line of frame 2, rewrite goes into its lit period
    localparam int REWRITE_LINE = 2 * FRAME_LINES;
    localparam int REWRITE_COUNT = 8;
    localparam int LAST_LINE = 4 * FRAME_LINES;
    // generous bound on one line, shift plus MSB lit time
    localparam int LINE_LIMIT = 2 * (WIDTH + (`BRIGHTNESS_BASE_TIMEOUT << (LEVELS - 1)));

    logic reset;
    logic clk_in;
    logic wr_en;
    pixel_write_t wr;
    hub75_bus_t hub75;

    integer seed;
    // image as the panel should show it
    pixel_rgb_t image [2*HALF][WIDTH];

    // monitor state
    int latch_count;
    int pixel_count;
    int oe_count;
    line_bits_t prev_bits;
    logic prev_latch;
    logic prev_pixel;
    logic prev_oe;

    int pass_count;
    int fail_count;
    int test_errors [1:6];
    bit timed_out;

    led_matrix dut (
        .reset (reset),
        .clk_in(clk_in),
        .wr_en (wr_en),
        .wr    (wr),
        .hub75 (hub75)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    // line n: four planes per row, MSB first, rows wrap after HALF
    function automatic row_addr_t line_row(input int line);
        return row_addr_t'((line / LEVELS) % HALF);
    endfunction

    function automatic int line_plane(input int line);
        return LEVELS - 1 - (line % LEVELS);
    endfunction

    // base lit time doubled per plane index
    function automatic int lit_cycles(input int line);
        return `BRIGHTNESS_BASE_TIMEOUT << line_plane(line);
    endfunction

    // bits of line n at one column, upper and lower half
    function automatic line_bits_t expected_bits(input int line, input int column);
        pixel_rgb_t upper;
        pixel_rgb_t lower;
        line_bits_t bits;
        int plane;
        int row;
        plane = line_plane(line);
        row = (line / LEVELS) % HALF;
        upper = image[row][column];
        lower = image[row + HALF][column];
        bits.r0 = upper.red[plane];
        bits.g0 = upper.green[plane];
        bits.b0 = upper.blue[plane];
        bits.r1 = lower.red[plane];
        bits.g1 = lower.green[plane];
        bits.b1 = lower.blue[plane];
        return bits;
    endfunction

    task automatic check_value(input int test_id, input string name,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (expected == actual) pass_count++;
        else begin
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
            fail_count++;
            test_errors[test_id]++;
        end
    endtask

    task automatic check_true(input int test_id, input bit condition, input string what);
        assert (condition) pass_count++;
        else begin
            $display("error: %s (line %0d)", what, latch_count);
            fail_count++;
            test_errors[test_id]++;
        end
    endtask

    // one sample per cycle, 1 ns after the rising edge
    task automatic sample_panel();
        int column;
        int test_id;
        if (hub75.clk_pixel) begin
            column = WIDTH - 1 - pixel_count;
            // frame 0 goes out while the image is still being written
            if (latch_count >= FRAME_LINES && column >= 0) begin
                test_id = (latch_count < REWRITE_LINE) ? 5 : 6;
                // bits loaded on the previous edge
                check_value(test_id,
                    $sformatf("line_bits line %0d column %0d", latch_count, column),
                    32'(expected_bits(latch_count, column)), 32'(prev_bits));
            end
            pixel_count++;
        end
        if (hub75.row_latch) begin
            check_true(2, !prev_latch, "row_latch stayed high for more than one cycle");
            check_true(2, prev_pixel, "row_latch did not follow the last pixel clock");
            check_value(2, "pixel clocks per line", WIDTH, pixel_count);
            check_value(3, $sformatf("row_address_active line %0d", latch_count),
                32'(line_row(latch_count)), 32'(hub75.row_address_active));
            if (latch_count > 0) begin
                check_value(4, $sformatf("output_enable cycles line %0d", latch_count - 1),
                    lit_cycles(latch_count - 1), oe_count);
            end
            // latch rises on the falling edge, timer takes it on this rising edge
            check_true(4, hub75.output_enable && !prev_oe,
                "output_enable did not rise with the row latch");
            latch_count++;
            pixel_count = 0;
            oe_count = hub75.output_enable ? 1 : 0;
        end else begin
            if (hub75.output_enable) begin
                oe_count++;
            end
            // nothing lit before the first line is latched
            if (latch_count == 0) begin
                check_value(1, "output_enable", 0, 32'(hub75.output_enable));
                check_value(1, "row_address_active", 0, 32'(hub75.row_address_active));
            end
        end
        prev_bits = hub75.line_bits;
        prev_latch = hub75.row_latch;
        prev_pixel = hub75.clk_pixel;
        prev_oe = hub75.output_enable;
    endtask

    always @(posedge clk_in) begin
        #1;
        if (!reset) begin
            sample_panel();
        end
    end

    task automatic wait_for_latches(input int target, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (latch_count < target && cycles < limit && !timed_out) begin
            @(negedge clk_in);
            cycles++;
        end
        if (latch_count < target && !timed_out) begin
            $display("timeout: waiting for %s, saw %0d of %0d row latches in %0d cycles",
                what, latch_count, target, cycles);
            timed_out = 1'b1;
        end
    endtask

    task automatic write_pixel(input pixel_write_t update);
        @(negedge clk_in);
        wr_en = 1'b1;
        wr = update;
    endtask

    task automatic stop_writing();
        @(negedge clk_in);
        wr_en = 1'b0;
        wr = '0;
    endtask

    task automatic report_test(input int test_id, input string name);
        if (timed_out) begin
            $display("test %0d %s: not finished", test_id, name);
        end else if (test_errors[test_id] == 0) begin
            $display("test %0d %s: ok", test_id, name);
        end else begin
            $display("test %0d %s: %0d errors", test_id, name, test_errors[test_id]);
        end
    endtask

    initial begin : main
        pixel_write_t update;
        reset = 1'b1;
        wr_en = 1'b0;
        wr = '0;
        seed = 32'h3153_b4b0;
        latch_count = 0;
        pixel_count = 0;
        oe_count = 0;
        prev_bits = '0;
        prev_latch = 1'b0;
        prev_pixel = 1'b0;
        prev_oe = 1'b0;
        pass_count = 0;
        fail_count = 0;
        timed_out = 1'b0;
        for (int t = 1; t <= 6; t++) begin
            test_errors[t] = 0;
        end
        for (int row = 0; row < 2 * HALF; row++) begin
            for (int column = 0; column < WIDTH; column++) begin
                image[row][column] = pixel_rgb_t'($random(seed));
            end
        end

        repeat (8) @(negedge clk_in);
        reset = 1'b0;

        wait_for_latches(1, LINE_LIMIT, "first row latch after reset");
        report_test(1, "reset state");

        // whole image, done long before frame 1 starts loading
        for (int row = 0; row < 2 * HALF; row++) begin
            for (int column = 0; column < WIDTH; column++) begin
                update.row = image_row_t'(row);
                update.column = column_addr_t'(column);
                update.pixel = image[row][column];
                write_pixel(update);
            end
        end
        stop_writing();

        wait_for_latches(REWRITE_LINE, 2 * FRAME_LINES * LINE_LIMIT, "end of frame 1");
        report_test(5, "image data over a full frame");

        // MSB lit period, no column is loaded for about 60 cycles
        wait_for_latches(REWRITE_LINE + 1, LINE_LIMIT, "first line of frame 2");
        for (int n = 0; n < REWRITE_COUNT; n++) begin
            update.row = image_row_t'($random(seed));
            update.column = column_addr_t'($random(seed));
            update.pixel = pixel_rgb_t'($random(seed));
            image[update.row][update.column] = update.pixel;
            write_pixel(update);
        end
        stop_writing();

        wait_for_latches(LAST_LINE, 2 * FRAME_LINES * LINE_LIMIT, "end of frame 3");
        report_test(2, "line shape");
        report_test(3, "scan order");
        report_test(4, "lit time");
        report_test(6, "rewrite");

        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hw
hw/matrix_pkg.sv
hw/timeout.sv
hw/brightness_timeout.sv
hw/matrix_scan.sv
hw/frame_store.sv
hw/led_matrix.sv
sim/tb_led_matrix.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the LED matrix testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

output=""
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    -f all.f --top-module tb_led_matrix -Mdir obj_dir \
    && output="$(./obj_dir/Vtb_led_matrix)" \
    || echo "verilator build or simulation did not complete"

printf '%s\n' "$output"

grep -qxF '*** PASSED ***' <<< "$output" \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
